// ==== hdl/dbg_cmd_unit.sv ====
`default_nettype none

module dbg_cmd_unit (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [7:0]           rx_byte,
    input  wire logic                 rx_valid,
    output logic [7:0]                tx_byte,
    output dbg_pkg::core_ctrl_t       ctrl,
    input  wire dbg_pkg::core_status_t status,
    input  wire logic [31:0]          reg_rdata,
    output logic                      led
);

    import dbg_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_echo,
        st_read_reg,
        st_replying
    } dbg_state_e;

    dbg_state_e state;

    // reply bytes leave from the top of the buffer
    logic [63:0] send_buf;
    logic [3:0]  send_cnt;

    logic run_q;
    logic step_q;
    logic led_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            tx_byte  <= 8'h00;
            send_cnt <= 4'd0;
            run_q    <= 1'b0;
            step_q   <= 1'b0;
            led_q    <= 1'b0;
        end else begin
            // step lasts a single cycle
            step_q <= 1'b0;
            if (rx_valid) begin
                case (state)
                    st_idle: begin
                        case (rx_byte)
                            cmd_nop: tx_byte <= 8'h00;
                            cmd_echo: begin
                                tx_byte <= 8'h01;
                                state   <= st_echo;
                            end
                            cmd_toggle_led: begin
                                tx_byte <= 8'h00;
                                led_q   <= ~led_q;
                            end
                            cmd_enable_clock: begin
                                tx_byte <= 8'h00;
                                run_q   <= 1'b1;
                            end
                            cmd_disable_clock: begin
                                tx_byte <= 8'h00;
                                run_q   <= 1'b0;
                            end
                            cmd_step_clock: begin
                                tx_byte <= 8'h00;
                                step_q  <= 1'b1;
                            end
                            cmd_get_pc: begin
                                tx_byte  <= 8'h00;
                                send_cnt <= 4'd4;
                                state    <= st_replying;
                            end
                            cmd_get_reg: begin
                                tx_byte <= 8'h00;
                                state   <= st_read_reg;
                            end
                            cmd_get_fetched_instr: begin
                                tx_byte  <= 8'h00;
                                send_cnt <= 4'd8;
                                state    <= st_replying;
                            end
                            cmd_echo_cc: tx_byte <= 8'hcc;
                            default: tx_byte <= 8'hff;
                        endcase
                    end
                    st_echo: begin
                        tx_byte <= rx_byte;
                        state   <= st_idle;
                    end
                    st_read_reg: begin
                        tx_byte  <= 8'h00;
                        send_cnt <= 4'd4;
                        state    <= st_replying;
                    end
                    st_replying: begin
                        // incoming bytes are ignored here
                        tx_byte  <= send_buf[63:56];
                        send_cnt <= send_cnt - 4'd1;
                        if (send_cnt == 4'd1) begin
                            state <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // payload capture for the multi-byte replies
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            if (state == st_idle && rx_byte == cmd_get_pc) begin
                send_buf <= {status.pc, 32'h0};
            end else if (state == st_idle && rx_byte == cmd_get_fetched_instr) begin
                send_buf <= {status.pc, status.instr};
            end else if (state == st_read_reg) begin
                send_buf <= {reg_rdata, 32'h0};
            end else if (state == st_replying) begin
                send_buf <= {send_buf[55:0], 8'h00};
            end
        end
    end

    // index byte drives the read port directly so data is ready at rx_valid
    assign ctrl.run     = run_q;
    assign ctrl.step    = step_q;
    assign ctrl.reg_sel = rx_byte[reg_aw-1:0];

    assign led = led_q;

endmodule

`default_nettype wire

// ==== hdl/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

    // data path and fetch sizes
    localparam int xlen      = 32;
    localparam int rom_words = 32;
    localparam int rom_aw    = $clog2(rom_words);
    localparam int reg_count = 32;
    localparam int reg_aw    = $clog2(reg_count);

    // debug command codes, anything else answers ff
    typedef enum logic [7:0] {
        cmd_nop               = 8'h00,
        cmd_echo              = 8'h01,
        cmd_toggle_led        = 8'h02,
        cmd_enable_clock      = 8'h03,
        cmd_disable_clock     = 8'h04,
        cmd_step_clock        = 8'h05,
        cmd_get_pc            = 8'h06,
        cmd_get_reg           = 8'h07,
        cmd_get_fetched_instr = 8'h09,
        cmd_echo_cc           = 8'hcc
    } dbg_cmd_e;

    // opcodes of the two executed instructions
    localparam logic [6:0] opc_addi = 7'b0010011;
    localparam logic [6:0] opc_lui  = 7'b0110111;

    // one instruction word seen as i-type or u-type
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } instr_u;

    typedef struct packed {
        logic              run;
        logic              step;
        logic [reg_aw-1:0] reg_sel;
    } core_ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } core_status_t;

endpackage

`default_nettype wire

// ==== hdl/spi_byte_slave.sv ====
`default_nettype none

module spi_byte_slave (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       sclk,
    input  wire logic       mosi,
    input  wire logic       ss,
    output logic            miso,
    input  wire logic [7:0] tx_byte,
    output logic [7:0]      rx_byte,
    output logic            rx_valid
);

    // two-flop synchronizers for the pins
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] ss_sync;

    // previous synchronized levels for edge detection
    logic sclk_q;
    logic ss_q;

    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;

    logic sclk_rise;
    logic sclk_fall;
    logic ss_fall;
    logic ss_active;

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_sync <= 2'b00;
            ss_sync   <= 2'b11;
            sclk_q    <= 1'b0;
            ss_q      <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[0], sclk};
            ss_sync   <= {ss_sync[0], ss};
            sclk_q    <= sclk_sync[1];
            ss_q      <= ss_sync[1];
        end
    end

    // data pin needs no reset
    always_ff @(posedge clk) begin
        mosi_sync <= {mosi_sync[0], mosi};
    end

    assign ss_active = ~ss_sync[1];
    assign sclk_rise = sclk_sync[1] & ~sclk_q;
    assign sclk_fall = ~sclk_sync[1] & sclk_q;
    assign ss_fall   = ss_q & ~ss_sync[1];

    // receive side
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt  <= 3'd0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!ss_active) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ss_active && sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {rx_shift[6:0], mosi_sync[1]};
            end
        end
    end

    // transmit side, msb leads on the pin before the first rising edge
    always_ff @(posedge clk) begin
        if (ss_fall) begin
            tx_shift <= tx_byte;
        end else if (ss_active && sclk_fall) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign miso = tx_shift[7];

endmodule

`default_nettype wire

// ==== hdl/spi_debug_soc.sv ====
`default_nettype none

module spi_debug_soc (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic sclk,
    input  wire logic mosi,
    input  wire logic ss,
    output logic      miso,
    output logic      led
);

    import dbg_pkg::*;

    logic [7:0]   rx_byte;
    logic         rx_valid;
    logic [7:0]   tx_byte;
    core_ctrl_t   ctrl;
    core_status_t status;
    logic [31:0]  reg_rdata;

    // spi pins to bytes
    spi_byte_slave u_spi (
        .clk      (clk),
        .rst      (rst),
        .sclk     (sclk),
        .mosi     (mosi),
        .ss       (ss),
        .miso     (miso),
        .tx_byte  (tx_byte),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    dbg_cmd_unit u_dbg (
        .clk       (clk),
        .rst       (rst),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .tx_byte   (tx_byte),
        .ctrl      (ctrl),
        .status    (status),
        .reg_rdata (reg_rdata),
        .led       (led)
    );

    // target processor, halted until run or step
    step_core u_core (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .status    (status),
        .reg_rdata (reg_rdata)
    );

endmodule

`default_nettype wire

// ==== hdl/step_core.sv ====
`default_nettype none

module step_core (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire dbg_pkg::core_ctrl_t ctrl,
    output dbg_pkg::core_status_t    status,
    output logic [31:0]              reg_rdata
);

    import dbg_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] rom [rom_words];
    logic [xlen-1:0] regs [reg_count];

    instr_u          cur;
    logic            advance;
    logic            wr_en;
    logic [4:0]      wr_addr;
    logic [xlen-1:0] wr_data;
    logic [xlen-1:0] imm_i;

    initial begin
        $readmemh("rom.hex", rom);
    end

    // index wraps every 128 bytes of pc
    assign cur     = rom[pc[rom_aw+1:2]];
    assign advance = ctrl.run | ctrl.step;
    assign imm_i   = {{(xlen-12){cur.i_fmt.imm[11]}}, cur.i_fmt.imm};

    // decode, other words fall through as no-ops
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = cur.i_fmt.rd;
        wr_data = '0;
        if (cur.u_fmt.opcode == opc_lui) begin
            wr_en   = 1'b1;
            wr_addr = cur.u_fmt.rd;
            wr_data = {cur.u_fmt.imm, 12'h000};
        end else if (cur.i_fmt.opcode == opc_addi && cur.i_fmt.funct3 == 3'b000) begin
            wr_en   = 1'b1;
            wr_addr = cur.i_fmt.rd;
            wr_data = regs[cur.i_fmt.rs1] + imm_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pc + 32'd4;
        end
    end

    // x0 is never written so it stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (advance && wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign reg_rdata    = regs[ctrl.reg_sel];
    assign status.pc    = pc;
    assign status.instr = cur;

endmodule

`default_nettype wire

// ==== rom.hex ====
// one 32-bit instruction word per line, index 0 to 31
00500093
fff08113
123451b7
67818193
06410213
00000013
002082b3
fffff337
7ff30313
00108093
80008393
abcde437
12340493
0050a513
fff18513
000015b7
02a58613
f9c60693
80000737
fff70793
00178813
00380f93
00710113
55555037
00908013
010f8893
0000006f
ffd88913
00fff9b7
55598a13
00118193
002a0a93

// ==== run.sh ====
#!/bin/sh
# build and run the debug port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module spi_debug_soc_tb -f verilog.f -o sim_tb

# the simulator status is not trusted, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST OK" sim.log

// ==== sim/spi_debug_soc_properties.sv ====
`default_nettype none

module spi_debug_soc_properties (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       rx_valid,
    input wire logic [7:0] tx_byte,
    input wire logic       step,
    input wire logic       run
);

    // one step command retires one instruction
    step_single_cycle: assert property (@(posedge clk) disable iff (rst) step |=> !step)
        else $error("step pulse longer than one cycle");

    run_low_after_reset: assert property (@(posedge clk) rst |=> !run)
        else $error("run high right after reset");

    // reply byte moves only when a byte was handled
    tx_changes_on_byte: assert property (@(posedge clk) disable iff (rst)
        (tx_byte != $past(tx_byte)) |-> ($past(rx_valid) || $past(rst)))
        else $error("tx_byte changed without a received byte");

endmodule

bind dbg_cmd_unit spi_debug_soc_properties props (
    .clk      (clk),
    .rst      (rst),
    .rx_valid (rx_valid),
    .tx_byte  (tx_byte),
    .step     (ctrl.step),
    .run      (ctrl.run)
);

`default_nettype wire

// ==== sim/spi_debug_soc_tb.sv ====
`default_nettype none

module spi_debug_soc_tb;

    import dbg_pkg::*;

    // about 600 bytes over all tests at under 100 cycles each, plus the run wait
    localparam int byte_budget    = 600;
    localparam int timeout_cycles = byte_budget * 100 + 2000;

    logic clk, rst, sclk, mosi, ss;
    wire logic miso, led;

    int seed = 32'hd6509784;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int bytes_sent = 0;

    // reference model state
    logic [31:0] rom_m [32];
    logic [31:0] regs_m [32];
    logic [31:0] pc_m;
    logic        led_m;
    int          m_state;
    logic [7:0]  reply_q [$];
    logic [7:0]  exp_reply;

    spi_debug_soc dut (
        .clk  (clk),
        .rst  (rst),
        .sclk (sclk),
        .mosi (mosi),
        .ss   (ss),
        .miso (miso),
        .led  (led)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic void exec_one();
        logic [31:0] w;
        logic [31:0] val;
        logic        wr;
        w = rom_m[pc_m[6:2]];
        wr = 1'b0;
        val = 32'h0;
        if (w[6:0] == 7'h37) begin
            wr = 1'b1;
            val = {w[31:12], 12'h000};
        end else if (w[6:0] == 7'h13 && w[14:12] == 3'b000) begin
            wr = 1'b1;
            val = regs_m[w[19:15]] + {{20{w[31]}}, w[31:20]};
        end
        if (wr && w[11:7] != 5'd0) regs_m[w[11:7]] = val;
        pc_m = pc_m + 32'd4;
    endfunction

    function automatic void push_word(input logic [31:0] w);
        reply_q.push_back(w[31:24]);
        reply_q.push_back(w[23:16]);
        reply_q.push_back(w[15:8]);
        reply_q.push_back(w[7:0]);
    endfunction

    // returns the reply expected in the transfer after byte b
    function automatic logic [7:0] model_byte(input logic [7:0] b);
        logic [7:0] r;
        r = 8'h00;
        if (m_state == 1) begin
            r = b;
            m_state = 0;
        end else if (m_state == 2) begin
            push_word(regs_m[b[4:0]]);
            m_state = 3;
        end else if (m_state == 3) begin
            r = reply_q.pop_front();
            if (reply_q.size() == 0) m_state = 0;
        end else begin
            case (b)
                cmd_nop, cmd_enable_clock, cmd_disable_clock: r = 8'h00;
                cmd_echo: begin
                    r = 8'h01;
                    m_state = 1;
                end
                cmd_toggle_led: led_m = ~led_m;
                cmd_step_clock: exec_one();
                cmd_get_reg: m_state = 2;
                cmd_echo_cc: r = 8'hcc;
                cmd_get_pc: begin
                    push_word(pc_m);
                    m_state = 3;
                end
                cmd_get_fetched_instr: begin
                    push_word(pc_m);
                    push_word(rom_m[pc_m[6:2]]);
                    m_state = 3;
                end
                default: r = 8'hff;
            endcase
        end
        return r;
    endfunction

    function automatic logic is_known(input logic [7:0] c);
        return (c <= 8'h07) || c == 8'h09 || c == 8'hcc;
    endfunction

    // one spi mode 0 byte, msb first, returns what came back on miso
    task automatic xfer(input logic [7:0] b, output logic [7:0] r);
        int i;
        @(posedge clk);
        ss <= 1'b0;
        mosi <= b[7];
        for (i = 7; i >= 0; i--) begin
            repeat (5) @(posedge clk);
            r[i] = miso;
            sclk <= 1'b1;
            repeat (5) @(posedge clk);
            sclk <= 1'b0;
            if (i > 0) mosi <= b[i-1];
        end
        repeat (5) @(posedge clk);
        ss <= 1'b1;
        repeat (8) @(posedge clk);
        bytes_sent++;
    endtask

    task automatic send(input logic [7:0] b);
        logic [7:0] got;
        xfer(b, got);
        check("miso", {24'h0, got}, {24'h0, exp_reply});
        exp_reply = model_byte(b);
    endtask

    task automatic send_n(input logic [7:0] b, input int n);
        repeat (n) send(b);
    endtask

    task automatic test_done(input string name, input int err_start);
        $display("%s finished with %0d errors", name, errors - err_start);
    endtask

    initial begin
        logic [7:0]  c;
        logic [7:0]  got;
        logic [31:0] p;
        int          n;
        int          e0;
        clk = 1'b0;
        rst = 1'b1;
        sclk = 1'b0;
        mosi = 1'b0;
        ss = 1'b1;
        $readmemh("rom.hex", rom_m);
        for (int i = 0; i < 32; i++) regs_m[i] = 32'h0;
        pc_m = 32'h0;
        led_m = 1'b0;
        m_state = 0;
        exp_reply = 8'h00;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);

        e0 = errors;
        send(cmd_nop);
        repeat (20) begin
            send(cmd_echo);
            send(8'($random(seed)));
        end
        send(cmd_echo_cc);
        // read flash has no handler here
        send(8'h08);
        repeat (10) begin
            do c = 8'($random(seed)); while (is_known(c));
            send(c);
        end
        send(cmd_nop);
        test_done("simple commands", e0);

        e0 = errors;
        repeat (4) begin
            n = $random(seed) & 32'hf;
            send_n(cmd_toggle_led, n);
            send(cmd_nop);
            check("led", {31'h0, led}, {31'h0, led_m});
        end
        test_done("led", e0);

        e0 = errors;
        repeat (3) begin
            n = $random(seed) & 32'hf;
            send_n(cmd_step_clock, n);
            send(cmd_get_pc);
            send_n(cmd_nop, 4);
            send(cmd_get_pc);
            send_n(cmd_nop, 4);
        end
        test_done("stepping", e0);

        e0 = errors;
        send_n(cmd_step_clock, 32);
        for (int i = 0; i < 32; i++) begin
            send(cmd_get_reg);
            send(8'(i));
            send_n(cmd_nop, 4);
        end
        test_done("registers", e0);

        e0 = errors;
        repeat (3) begin
            n = $random(seed) & 32'h7;
            send_n(cmd_step_clock, n);
            send(cmd_get_fetched_instr);
            send_n(cmd_nop, 8);
        end
        test_done("fetched instruction", e0);

        e0 = errors;
        send(cmd_enable_clock);
        repeat ($random(seed) & 32'hff) @(posedge clk);
        send(cmd_disable_clock);
        // pc unknown to the model here, read it raw
        xfer(cmd_get_pc, got);
        check("miso", {24'h0, got}, {24'h0, exp_reply});
        xfer(cmd_nop, got);
        check("miso", {24'h0, got}, 32'h0);
        for (int i = 3; i >= 0; i--) begin
            xfer(cmd_nop, got);
            p[i*8 +: 8] = got;
        end
        exp_reply = 8'h00;
        check("pc low bits", {30'h0, p[1:0]}, 32'h0);
        n = int'((p - pc_m) >> 2);
        if (p < pc_m || n > 4096) begin
            errors++;
            $display("pc after run is not reachable from the model pc %h", pc_m);
        end else begin
            $display("run advanced %0d rom passes plus %0d words", n / 32, n % 32);
            repeat (n) exec_one();
        end
        repeat (2) begin
            send(cmd_get_pc);
            send_n(cmd_nop, 4);
        end
        send(cmd_get_fetched_instr);
        send_n(cmd_nop, 8);
        for (int i = 1; i < 32; i += 5) begin
            send(cmd_get_reg);
            send(8'(i));
            send_n(cmd_nop, 4);
        end
        send(cmd_nop);
        test_done("run and halt", e0);

        $display("%0d checks, %0d errors, %0d bytes", checks, errors, bytes_sent);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/dbg_pkg.sv
hdl/spi_byte_slave.sv
hdl/dbg_cmd_unit.sv
hdl/step_core.sv
hdl/spi_debug_soc.sv
sim/spi_debug_soc_properties.sv
sim/spi_debug_soc_tb.sv
